// ==== uart_alu_top.f ====
+incdir+design
design/uart_pkg.sv
design/alu_pkg.sv
design/baud_tick_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/alu.sv
design/alu_frame_ctrl.sv
design/uart_alu_top.sv
bench/clock_gen.sv
bench/uart_alu_tb.sv

// ==== bench/uart_alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_defines.svh"

module uart_alu_tb;

	// clk cycles in one bit on either line
	localparam int BIT_CYCLES    = `UART_OVERSAMPLE * `UART_BAUD_DIV;
	localparam int START_TIMEOUT = 48 * BIT_CYCLES;
	localparam int RESET_TIMEOUT = 100;

	logic clk;
	logic reset;
	logic rx_line;
	logic tx_line;

	integer seed;
	int     errors;
	int     tests_run;
	int     tests_failed;

	clock_gen u_clk
	(
		.clk   (clk),
		.reset (reset)
	);

	uart_alu_top uut
	(
		.clk     (clk),
		.reset   (reset),
		.rx_line (rx_line),
		.tx_line (tx_line)
	);

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic [7:0] expected_result(input logic [7:0] a, input logic [7:0] b,
		input logic [7:0] op);
		logic [7:0] r;
		int         k;
		r = 8'h00;
		case (op)
			8'h20: r = a + b;
			// Two's complement subtract, wraps at eight bits
			8'h22: r = a + ~b + 8'd1;
			8'h24: r = a & b;
			8'h25: r = a | b;
			8'h26: r = a ^ b;
			8'h27: r = ~a & ~b;
			// One step per shift, fill bit set by opcode bit 0
			8'h02, 8'h03:
			begin
				r = a;
				for (k = 0; k < b[2:0]; k++)
					r = {op[0] ? r[7] : 1'b0, r[7:1]};
			end
			default: r = 8'h00;
		endcase
		return r;
	endfunction

	// The eight defined opcodes by index
	function automatic logic [7:0] opcode_at(input int index);
		case (index)
			0: return 8'h20;
			1: return 8'h22;
			2: return 8'h24;
			3: return 8'h25;
			4: return 8'h26;
			5: return 8'h27;
			6: return 8'h02;
			default: return 8'h03;
		endcase
	endfunction

	//////////////////////////////
	// Serial line helpers
	//////////////////////////////

	// Entered on a rising edge, leaves on one
	task automatic send_byte(input logic [7:0] value);
		int i;
		rx_line <= 1'b0;
		repeat (BIT_CYCLES)
			@(posedge clk);
		// LSB first
		for (i = 0; i < `UART_DATA_BITS; i++)
		begin
			rx_line <= value[i];
			repeat (BIT_CYCLES)
				@(posedge clk);
		end
		rx_line <= 1'b1;
		repeat (BIT_CYCLES)
			@(posedge clk);
	endtask

	// Falling edge, then samples at bit midpoints
	task automatic receive_byte(output logic [7:0] value, output logic ok);
		int   waited;
		int   i;
		logic prev;
		value  = 8'h00;
		ok     = 1'b0;
		waited = 0;
		prev   = tx_line;
		@(posedge clk);
		while (!(prev && !tx_line) && waited < START_TIMEOUT)
		begin
			prev = tx_line;
			@(posedge clk);
			waited++;
		end
		if (!(prev && !tx_line))
		begin
			$display("Timed out waiting for a response start bit at %0t", $time);
			errors++;
			return;
		end
		ok = 1'b1;
		// Middle of the start bit
		repeat (BIT_CYCLES / 2 - 1)
			@(posedge clk);
		assert (tx_line === 1'b0)
		else
		begin
			$display("FAIL %0t: start bit not low at its midpoint", $time);
			errors++;
			ok = 1'b0;
		end
		for (i = 0; i < `UART_DATA_BITS; i++)
		begin
			repeat (BIT_CYCLES)
				@(posedge clk);
			value[i] = tx_line;
		end
		repeat (BIT_CYCLES)
			@(posedge clk);
		assert (tx_line === 1'b1)
		else
		begin
			$display("FAIL %0t: stop bit not high at its midpoint", $time);
			errors++;
			ok = 1'b0;
		end
	endtask

	//////////////////////////////
	// Checks and reporting
	//////////////////////////////

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input logic ok,
		inout logic pass);
		if (!ok)
			pass = 1'b0;
		else
		begin
			assert (got === exp)
			else
			begin
				$display("FAIL %0t: response %h, expected %h", $time, got, exp);
				errors++;
				pass = 1'b0;
			end
		end
	endtask

	// Three bytes out, one response back
	task automatic run_request(input logic [7:0] a, input logic [7:0] b, input logic [7:0] op,
		input logic [7:0] exp, inout logic pass);
		logic [7:0] got;
		logic       ok;
		fork
			begin
				send_byte(a);
				send_byte(b);
				send_byte(op);
			end
			receive_byte(got, ok);
		join
		check_byte(got, exp, ok, pass);
	endtask

	task automatic report_test(input string name, input logic pass);
		tests_run++;
		if (!pass)
			tests_failed++;
		$display("Test %0d %s: %s", tests_run, name, pass ? "passed" : "failed");
	endtask

	task automatic idle_gap();
		repeat (2 * BIT_CYCLES)
			@(posedge clk);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		int         waited;
		int         low_cycles;
		int         i;
		int         j;
		logic       pass;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] op;
		logic [7:0] seq_a [0:2];
		logic [7:0] seq_b [0:2];
		logic [7:0] seq_op [0:2];
		logic [7:0] got [0:2];
		logic       ok [0:2];

		rx_line      = 1'b1;
		seed         = 32'h2a45;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;

		waited = 0;
		while (reset !== 1'b0 && waited < RESET_TIMEOUT)
		begin
			@(posedge clk);
			waited++;
		end
		if (reset !== 1'b0)
		begin
			$display("Reset was never released");
			errors++;
		end

		// Quiet line after reset
		pass       = 1'b1;
		low_cycles = 0;
		repeat (200 * `UART_BAUD_DIV)
		begin
			@(posedge clk);
			if (tx_line !== 1'b1)
				low_cycles++;
		end
		assert (low_cycles == 0)
		else
		begin
			$display("FAIL %0t: tx_line low for %0d idle cycles", $time, low_cycles);
			errors++;
			pass = 1'b0;
		end
		report_test("idle line after reset", pass);

		// Fixed wraparound cases
		pass = 1'b1;
		run_request(8'hF0, 8'h20, 8'h20, 8'h10, pass);
		idle_gap();
		run_request(8'h05, 8'h07, 8'h22, 8'hFE, pass);
		idle_gap();
		report_test("add and sub wraparound", pass);

		// Every opcode, shifts get a negative A and a nonzero amount
		pass = 1'b1;
		for (i = 0; i < 8; i++)
		begin
			op = opcode_at(i);
			a  = 8'($random(seed));
			b  = 8'($random(seed));
			if (op == 8'h02 || op == 8'h03)
			begin
				a[7] = 1'b1;
				if (b[2:0] == 3'd0)
					b[0] = 1'b1;
			end
			run_request(a, b, op, expected_result(a, b, op), pass);
			idle_gap();
		end
		report_test("all opcodes with random operands", pass);

		// Undefined opcode
		pass = 1'b1;
		a    = 8'($random(seed));
		b    = 8'($random(seed));
		run_request(a, b, 8'h55, 8'h00, pass);
		idle_gap();
		report_test("unknown opcode", pass);

		// Short low pulse, a quarter bit, then a real frame
		pass = 1'b1;
		rx_line <= 1'b0;
		repeat (BIT_CYCLES / 4)
			@(posedge clk);
		rx_line <= 1'b1;
		idle_gap();
		a  = 8'($random(seed));
		b  = 8'($random(seed));
		op = opcode_at($random(seed) & 7);
		run_request(a, b, op, expected_result(a, b, op), pass);
		idle_gap();
		report_test("start bit glitch rejected", pass);

		// Nine bytes with no idle time between frames
		pass = 1'b1;
		for (i = 0; i < 3; i++)
		begin
			seq_a[i]  = 8'($random(seed));
			seq_b[i]  = 8'($random(seed));
			seq_op[i] = opcode_at($random(seed) & 7);
		end
		fork
			begin
				for (i = 0; i < 3; i++)
				begin
					send_byte(seq_a[i]);
					send_byte(seq_b[i]);
					send_byte(seq_op[i]);
				end
			end
			begin
				for (j = 0; j < 3; j++)
					receive_byte(got[j], ok[j]);
			end
		join
		for (i = 0; i < 3; i++)
			check_byte(got[i], expected_result(seq_a[i], seq_b[i], seq_op[i]), ok[i], pass);
		idle_gap();
		report_test("back-to-back requests", pass);

		$display("Tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen
(
	output logic clk,
	output logic reset
);

	// 10 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// Reset held across the first five rising edges
	initial
	begin
		reset = 1'b1;
		repeat (5)
			@(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== design/uart_alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_alu_top
(
	input  wire  clk,
	input  wire  reset,
	input  wire  rx_line,
	output logic tx_line
);

	import alu_pkg::*;

	logic    tick;
	word_t   rx_data;
	logic    rx_done;
	word_t   operand_a;
	word_t   operand_b;
	opcode_t opcode;
	word_t   result;
	word_t   tx_data;
	logic    tx_start;
	logic    tx_busy;

	// Shared 16x tick for both directions
	baud_tick_gen u_tick
	(
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	uart_rx u_rx
	(
		.clk     (clk),
		.reset   (reset),
		.tick    (tick),
		.rx_line (rx_line),
		.rx_data (rx_data),
		.rx_done (rx_done)
	);

	// Three bytes in, one result out
	alu_frame_ctrl u_ctrl
	(
		.clk       (clk),
		.reset     (reset),
		.rx_data   (rx_data),
		.rx_done   (rx_done),
		.tx_busy   (tx_busy),
		.result    (result),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.opcode    (opcode),
		.tx_data   (tx_data),
		.tx_start  (tx_start)
	);

	alu u_alu
	(
		.operand_a (operand_a),
		.operand_b (operand_b),
		.opcode    (opcode),
		.result    (result)
	);

	uart_tx u_tx
	(
		.clk      (clk),
		.reset    (reset),
		.tick     (tick),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_line  (tx_line),
		.tx_busy  (tx_busy)
	);

endmodule

`default_nettype wire

// ==== design/alu_frame_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_frame_ctrl
(
	input  wire              clk,
	input  wire              reset,
	input  alu_pkg::word_t   rx_data,
	input  wire              rx_done,
	input  wire              tx_busy,
	input  alu_pkg::word_t   result,
	output alu_pkg::word_t   operand_a,
	output alu_pkg::word_t   operand_b,
	output alu_pkg::opcode_t opcode,
	output alu_pkg::word_t   tx_data,
	output logic             tx_start
);

	import alu_pkg::*;

	frame_state_t state;

	// Byte that came in while a result was still waiting
	word_t held_a;
	logic  a_held;

	logic launch;

	// Result goes out as soon as the transmitter is free
	assign launch = (state == SEND) && !tx_busy;

	//////////////////////////////
	// Frame sequencing
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= WAIT_A;
			a_held   <= 1'b0;
			tx_start <= 1'b0;
		end
		else
		begin
			tx_start <= launch;
			case (state)
				WAIT_A:  if (rx_done) state <= WAIT_B;
				WAIT_B:  if (rx_done) state <= WAIT_OP;
				WAIT_OP: if (rx_done) state <= SEND;
				SEND:
				begin
					if (launch)
					begin
						// Early byte already counts as the next A
						state  <= (a_held || rx_done) ? WAIT_B : WAIT_A;
						a_held <= 1'b0;
					end
					else if (rx_done)
						a_held <= 1'b1;
				end
			endcase
		end
	end

	// Operand and result registers
	always_ff @(posedge clk)
	begin
		if (rx_done)
		begin
			case (state)
				WAIT_A:  operand_a <= rx_data;
				WAIT_B:  operand_b <= rx_data;
				WAIT_OP: opcode    <= opcode_t'(rx_data);
				SEND:    held_a    <= rx_data;
			endcase
		end
		if (launch)
		begin
			tx_data <= result;
			if (a_held)
				operand_a <= held_a;
			else if (rx_done)
				operand_a <= rx_data;
		end
	end

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
(
	input  alu_pkg::word_t   operand_a,
	input  alu_pkg::word_t   operand_b,
	input  alu_pkg::opcode_t opcode,
	output alu_pkg::word_t   result
);

	import alu_pkg::*;

	// Shift amount, only the low bits of B matter
	logic [2:0] shamt;

	assign shamt = operand_b[2:0];

	always_comb
	begin
		case (opcode)
			// Arithmetic wraps at eight bits
			OP_ADD: result = operand_a + operand_b;
			OP_SUB: result = operand_a - operand_b;
			// Bitwise
			OP_AND: result = operand_a & operand_b;
			OP_OR:  result = operand_a | operand_b;
			OP_XOR: result = operand_a ^ operand_b;
			OP_NOR: result = ~(operand_a | operand_b);
			// Logical shift fills with zeros
			OP_SRL: result = operand_a >> shamt;
			// Arithmetic shift copies the sign bit
			OP_SRA: result = word_t'($signed(operand_a) >>> shamt);
			// Unknown codes still get a reply
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_defines.svh"

module uart_tx
(
	input  wire            clk,
	input  wire            reset,
	input  wire            tick,
	input  wire            tx_start,
	input  alu_pkg::word_t tx_data,
	output logic           tx_line,
	output logic           tx_busy
);

	import uart_pkg::*;
	import alu_pkg::*;

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_DATA_BITS);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_DATA_BITS - 1);

	tx_state_t         state;
	logic [TICK_W-1:0] tick_cnt;
	logic [BIT_W-1:0]  bit_cnt;
	word_t             shift;

	//////////////////////////////
	// Bit sequencer
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			tx_busy  <= 1'b0;
		end
		else
		begin
			case (state)
				TX_IDLE:
				begin
					tick_cnt <= '0;
					bit_cnt  <= '0;
					if (tx_start)
						tx_busy <= 1'b1;
					// Start bit begins on the next tick
					if (tx_busy && tick)
						state <= TX_START;
				end
				TX_START:
				begin
					if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == TICK_LAST)
							state <= TX_DATA;
					end
				end
				TX_DATA:
				begin
					if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
						if (tick_cnt == TICK_LAST)
						begin
							if (bit_cnt == BIT_LAST)
								state <= TX_STOP;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				TX_STOP:
				begin
					if (tick)
					begin
						tick_cnt <= tick_cnt + 1'b1;
						// Busy drops once the full stop bit is out
						if (tick_cnt == TICK_LAST)
						begin
							state   <= TX_IDLE;
							tx_busy <= 1'b0;
						end
					end
				end
			endcase
		end
	end

	// Shift register, bit zero is always the one on the line
	always_ff @(posedge clk)
	begin
		if (state == TX_IDLE && tx_start)
			shift <= tx_data;
		else if (state == TX_DATA && tick && tick_cnt == TICK_LAST)
			shift <= shift >> 1;
	end

	// Line level follows the state
	always_comb
	begin
		case (state)
			TX_START: tx_line = 1'b0;
			TX_DATA:  tx_line = shift[0];
			default:  tx_line = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_defines.svh"

module uart_rx
(
	input  wire            clk,
	input  wire            reset,
	input  wire            tick,
	input  wire            rx_line,
	output alu_pkg::word_t rx_data,
	output logic           rx_done
);

	import uart_pkg::*;
	import alu_pkg::*;

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_DATA_BITS);

	// Start bit checked half way, data bits a full bit apart
	localparam logic [TICK_W-1:0] TICK_HALF = TICK_W'(`UART_OVERSAMPLE / 2 - 1);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_DATA_BITS - 1);

	//////////////////////////////
	// Line synchronizer
	//////////////////////////////

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;

	// Idle line is high, so reset to one to avoid a false edge
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	//////////////////////////////
	// Oversampling FSM
	//////////////////////////////

	rx_state_t         state;
	logic [TICK_W-1:0] tick_cnt;
	logic [BIT_W-1:0]  bit_cnt;
	word_t             buffer;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= RX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			rx_done  <= 1'b0;
		end
		else
		begin
			rx_done <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					// Falling edge starts a frame
					tick_cnt <= '0;
					bit_cnt  <= '0;
					if (rx_prev && !rx_sync)
						state <= RX_START;
				end
				RX_START:
				begin
					if (tick)
					begin
						if (tick_cnt == TICK_HALF)
						begin
							tick_cnt <= '0;
							// Still low in mid start bit, else a glitch
							state <= rx_sync ? RX_IDLE : RX_DATA;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				RX_DATA:
				begin
					if (tick)
					begin
						if (tick_cnt == TICK_LAST)
						begin
							tick_cnt <= '0;
							if (bit_cnt == BIT_LAST)
								state <= RX_STOP;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				RX_STOP:
				begin
					// Stop value not checked, strobe and re-arm
					if (tick)
					begin
						if (tick_cnt == TICK_LAST)
						begin
							rx_done <= 1'b1;
							state   <= RX_IDLE;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// Data path, LSB arrives first so shift in from the top
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && tick && tick_cnt == TICK_LAST)
			buffer <= {rx_sync, buffer[$bits(word_t)-1:1]};
		if (state == RX_STOP && tick && tick_cnt == TICK_LAST)
			rx_data <= buffer;
	end

endmodule

`default_nettype wire

// ==== design/baud_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_defines.svh"

module baud_tick_gen
(
	input  wire  clk,
	input  wire  reset,
	output logic tick
);

	localparam int DIV   = `UART_BAUD_DIV;
	localparam int CNT_W = (DIV > 2) ? $clog2(DIV) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(DIV - 1);

	logic [CNT_W-1:0] count;

	// Down counter, reload when empty
	// Tick registered on the step from one to zero
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			tick  <= 1'b0;
		end
		else
		begin
			if (count == '0)
				count <= RELOAD;
			else
				count <= count - 1'b1;
			tick <= (count == CNT_W'(1));
		end
	end

endmodule

`default_nettype wire

// ==== design/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

	// One operand or result byte
	typedef logic [7:0] word_t;

	// Operation codes as sent on the wire
	typedef enum logic [7:0]
	{
		OP_ADD = 8'h20,
		OP_SUB = 8'h22,
		OP_AND = 8'h24,
		OP_OR  = 8'h25,
		OP_XOR = 8'h26,
		OP_NOR = 8'h27,
		OP_SRL = 8'h02,
		OP_SRA = 8'h03
	} opcode_t;

	// Byte collection FSM
	typedef enum logic [1:0]
	{
		WAIT_A  = 2'd0,
		WAIT_B  = 2'd1,
		WAIT_OP = 2'd2,
		SEND    = 2'd3
	} frame_state_t;

endpackage

`default_nettype wire

// ==== design/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

	// Receiver FSM states
	typedef enum logic [1:0]
	{
		RX_IDLE  = 2'd0,
		RX_START = 2'd1,
		RX_DATA  = 2'd2,
		RX_STOP  = 2'd3
	} rx_state_t;

	// Transmitter FSM states
	typedef enum logic [1:0]
	{
		TX_IDLE  = 2'd0,
		TX_START = 2'd1,
		TX_DATA  = 2'd2,
		TX_STOP  = 2'd3
	} tx_state_t;

endpackage

`default_nettype wire

// ==== design/uart_defines.svh ====
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Line timing constants shared by the serial blocks

// clk cycles per oversampling tick
// Small value keeps simulation short
// Needs to be at least 2
`define UART_BAUD_DIV 4

// Ticks per bit on the line
`define UART_OVERSAMPLE 16

// Data bits per character, no parity
`define UART_DATA_BITS 8

`endif
